// ==== decode_tests.txt ====
# W reg value (hex) writes a register through the writeback port
# D name instr pc taken target rs_data rt_data funct rd shamt
#   mem_op store size unsign link_en link_reg link_data illegal (all hex)
W 01 00000011
W 02 00000022
W 03 00000022
W 04 00400100
W 05 00000100
W 06 00000066
# Register 0 ignores writes
W 00 deadbeef
# R type ALU, rs of srl is register 0
D add_r6 00223020 00001000 0 00000000 00000011 00000022 20 06 00 0 0 0 0 0 00 00000000 0
D srl_r7 00013902 00001004 0 00000000 00000000 00000011 02 07 04 0 0 0 0 0 00 00000000 0
# Branches
D beq_tkn 10430010 00001000 1 00001044 00000022 00000022 00 00 00 0 0 0 0 0 00 00000000 0
D beq_not 1022fffc 00002000 0 00001ff4 00000011 00000022 00 00 00 0 0 0 0 0 00 00000000 0
D bne_tkn 14220008 00003000 1 00003024 00000011 00000022 00 00 00 0 0 0 0 0 00 00000000 0
D bne_not 14430004 00003100 0 00003114 00000022 00000022 00 00 00 0 0 0 0 0 00 00000000 0
# Jumps
D j 08100040 30000010 1 30400100 00000000 00000000 00 00 00 0 0 0 0 0 00 00000000 0
D jal 0c000400 00004000 1 00001000 00000000 00000000 00 00 00 0 0 0 0 1 1f 00004004 0
D jr 00800008 00005000 1 00400100 00400100 00000000 00 00 00 0 0 0 0 0 00 00000000 0
D jalr 00804809 00005100 1 00400100 00400100 00000000 00 09 00 0 0 0 0 1 09 00005104 0
# Immediate arithmetic, loads and stores
D ori 342a0005 00006000 0 00000000 00000011 00000000 05 00 00 0 0 0 0 0 00 00000000 0
D lw 8ca60010 00006004 0 00000000 00000100 00000066 03 00 00 1 0 3 0 0 00 00000000 0
D lh 84a60002 00006008 0 00000000 00000100 00000066 01 00 00 1 0 1 0 0 00 00000000 0
D lbu 90a60003 0000600c 0 00000000 00000100 00000066 04 00 00 1 0 0 1 0 00 00000000 0
D sw aca60004 00006010 0 00000000 00000100 00000066 03 00 00 1 1 3 0 0 00 00000000 0
D sb a0a60001 00006014 0 00000000 00000100 00000066 00 00 00 1 1 0 0 0 00 00000000 0
# Undefined opcodes
D bad_3f fc220000 00007000 0 00000000 00000000 00000000 00 00 00 0 0 0 0 0 00 00000000 1
D bad_01 04220000 00007004 0 00000000 00000000 00000000 00 00 00 0 0 0 0 0 00 00000000 1

// ==== all.f ====
mips_pkg.sv
instruction_decoder.sv
register_file.sv
branch_resolver.sv
decode_stage.sv
tb_decode_stage.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the decode stage testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --top-module tb_decode_stage -Mdir obj_dir -f all.f
	./obj_dir/Vtb_decode_stage

clean:
	rm -rf obj_dir

// ==== tb_decode_stage.sv ====
`timescale 1ns/10ps

module tb_decode_stage;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_valid;
    logic [31:0] i_instr;
    logic [31:0] i_pc;
    logic        i_wb_en;
    logic [4:0]  i_wb_addr;
    logic [31:0] i_wb_data;

    logic        o_valid;
    logic [5:0]  o_funct;
    logic [31:0] o_rs_data;
    logic [31:0] o_rt_data;
    logic [4:0]  o_rt;
    logic [4:0]  o_rd;
    logic [4:0]  o_shamt;
    logic [15:0] o_imm;
    logic        o_immediate;
    logic        o_mem_op;
    logic        o_mem_store;
    logic [1:0]  o_mem_size;
    logic        o_unsign;
    logic        o_branch_taken;
    logic [31:0] o_branch_target;
    logic        o_link_en;
    logic [4:0]  o_link_reg;
    logic [31:0] o_link_data;
    logic        o_illegal;

    logic [8*16-1:0] test_name;
    logic [31:0]     exp [0:14];  // Expected values in file column order
    integer          decode_count;

    decode_stage decode_stage_inst (.*);

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    task automatic abort_run(input string reason);
        $display("%0s", reason);
        $display("Errors found");
        $fatal(1, "decode stage test stopped");
    endtask

    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("FAIL %0s %0s: expected %h, actual %h",
                                test_name, field, expected, actual));
        end
    endtask

    // Operand fields that reach the ID/EX register for each instruction class
    task automatic expected_operands(input mips_pkg::instr_t word, output logic [4:0] rt,
                                     output logic [15:0] imm, output logic immediate);
        logic [2:0] group;
        group     = word.i_fmt.opcode[5:3];
        rt        = '0;
        imm       = '0;
        immediate = 1'b0;
        if (word.r_fmt.opcode == mips_pkg::OP_RTYPE) begin
            if (word.r_fmt.funct != mips_pkg::FN_JR && word.r_fmt.funct != mips_pkg::FN_JALR) begin
                rt = word.r_fmt.rt;
            end
        end else if (word.i_fmt.opcode == mips_pkg::OP_BEQ ||
                     word.i_fmt.opcode == mips_pkg::OP_BNE) begin
            rt = word.i_fmt.rt;  // Compared with rs
        end else if (group == mips_pkg::OPG_ARITH || group == mips_pkg::OPG_LOAD ||
                     group == mips_pkg::OPG_STORE) begin
            rt        = word.i_fmt.rt;
            imm       = word.i_fmt.imm;
            immediate = 1'b1;
        end
    endtask

    task automatic write_register(input logic [4:0] addr, input logic [31:0] data);
        i_wb_en   = 1'b1;
        i_wb_addr = addr;
        i_wb_data = data;
        @(posedge i_clk);
        #5;
        i_wb_en = 1'b0;
    endtask

    task automatic decode_and_check(input logic [31:0] instr, input logic [31:0] pc);
        mips_pkg::instr_t word;
        int               waited;
        logic [4:0]       exp_rt;
        logic [15:0]      exp_imm;
        logic             exp_immediate;
        word    = instr;
        expected_operands(word, exp_rt, exp_imm, exp_immediate);
        i_valid = 1'b1;
        i_instr = instr;
        i_pc    = pc;
        @(posedge i_clk);
        #5;
        i_valid = 1'b0;
        waited  = 0;
        while (!o_valid && waited < 4) begin
            @(posedge i_clk);
            #5;
            waited++;
        end
        if (!o_valid) begin
            abort_run($sformatf("o_valid never rose within 4 cycles in test %0s", test_name));
        end
        $display("%0s: opcode %h rs %0d rt %0d imm %h", test_name, word.i_fmt.opcode,
                 word.i_fmt.rs, word.i_fmt.rt, word.i_fmt.imm);
        check_value("taken", exp[0], 32'(o_branch_taken));
        check_value("target", exp[1], o_branch_target);
        check_value("rs_data", exp[2], o_rs_data);
        check_value("rt_data", exp[3], o_rt_data);
        check_value("funct", exp[4], 32'(o_funct));
        check_value("rd", exp[5], 32'(o_rd));
        check_value("shamt", exp[6], 32'(o_shamt));
        check_value("mem_op", exp[7], 32'(o_mem_op));
        check_value("mem_store", exp[8], 32'(o_mem_store));
        check_value("mem_size", exp[9], 32'(o_mem_size));
        check_value("unsign", exp[10], 32'(o_unsign));
        check_value("link_en", exp[11], 32'(o_link_en));
        check_value("link_reg", exp[12], 32'(o_link_reg));
        check_value("link_data", exp[13], o_link_data);
        check_value("illegal", exp[14], 32'(o_illegal));
        check_value("rt", 32'(exp_rt), 32'(o_rt));
        check_value("imm", 32'(exp_imm), 32'(o_imm));
        check_value("immediate", 32'(exp_immediate), 32'(o_immediate));
    endtask

    initial begin
        integer           fd;
        integer           code;
        logic [8*8-1:0]   kind;
        logic [8*128-1:0] rest;
        logic [31:0]      wb_idx;
        logic [31:0]      wb_val;
        logic [31:0]      instr;
        logic [31:0]      pc;
        i_rst_n      = 1'b0;
        i_valid      = 1'b0;
        i_instr      = '0;
        i_pc         = '0;
        i_wb_en      = 1'b0;
        i_wb_addr    = '0;
        i_wb_data    = '0;
        test_name    = '0;
        decode_count = 0;
        fd = $fopen("decode_tests.txt", "r");
        if (fd == 0) begin
            abort_run("could not open decode_tests.txt");
        end
        repeat (16) @(posedge i_clk);
        #5;
        i_rst_n = 1'b1;
        while ($fscanf(fd, "%s", kind) == 1) begin
            if (kind[7:0] == "#") begin
                code = $fgets(rest, fd);                  // Comment line
            end else if (kind[7:0] == "W") begin
                code = $fscanf(fd, "%h %h", wb_idx, wb_val);
                if (code != 2) abort_run("malformed register write line in decode_tests.txt");
                write_register(wb_idx[4:0], wb_val);
            end else if (kind[7:0] == "D") begin
                code = $fscanf(fd, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                               test_name, instr, pc, exp[0], exp[1], exp[2], exp[3],
                               exp[4], exp[5], exp[6], exp[7], exp[8], exp[9], exp[10],
                               exp[11], exp[12], exp[13], exp[14]);
                if (code != 18) abort_run("malformed decode line in decode_tests.txt");
                decode_and_check(instr, pc);
                decode_count++;
            end else begin
                abort_run("unknown record type in decode_tests.txt");
            end
        end
        $fclose(fd);
        if (decode_count > 0) begin
            $display("No errors");
            $finish;
        end else begin
            abort_run("decode_tests.txt held no decode lines");
        end
    end

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage (
    input  logic        i_clk,
    input  logic        i_rst_n,

    input  logic        i_valid,
    input  logic [31:0] i_instr,
    input  logic [31:0] i_pc,

    input  logic        i_wb_en,          // Writeback port
    input  logic [4:0]  i_wb_addr,
    input  logic [31:0] i_wb_data,

    output logic        o_valid,
    output logic [5:0]  o_funct,
    output logic [31:0] o_rs_data,
    output logic [31:0] o_rt_data,
    output logic [4:0]  o_rt,
    output logic [4:0]  o_rd,
    output logic [4:0]  o_shamt,
    output logic [15:0] o_imm,
    output logic        o_immediate,
    output logic        o_mem_op,
    output logic        o_mem_store,
    output logic [1:0]  o_mem_size,
    output logic        o_unsign,
    output logic        o_branch_taken,
    output logic [31:0] o_branch_target,
    output logic        o_link_en,
    output logic [4:0]  o_link_reg,
    output logic [31:0] o_link_data,
    output logic        o_illegal
);

    logic [5:0]  dec_funct;
    logic [4:0]  dec_rs;
    logic [4:0]  dec_rt;
    logic [4:0]  dec_rd;
    logic [4:0]  dec_shamt;
    logic [15:0] dec_imm;
    logic [25:0] dec_addr_offset;
    logic        dec_pc_modify;
    logic        dec_link_ret;
    logic [1:0]  dec_addr_type;
    logic [4:0]  dec_link_reg;
    logic        dec_equal;
    logic        dec_immediate;
    logic        dec_mem_op;
    logic        dec_mem_type;
    logic [1:0]  dec_mem_size;
    logic        dec_unsign;
    logic        dec_illegal;

    logic [31:0] rs_data;
    logic [31:0] rt_data;

    logic        br_taken;
    logic [31:0] br_target;
    logic        br_link_en;
    logic [4:0]  br_link_reg;
    logic [31:0] br_link_data;

    instruction_decoder instruction_decoder_inst (
        .i_instr         (i_instr),
        .o_funct         (dec_funct),
        .o_rs            (dec_rs),
        .o_rt            (dec_rt),
        .o_rd            (dec_rd),
        .o_shamt         (dec_shamt),
        .o_imm           (dec_imm),
        .o_addr_offset   (dec_addr_offset),
        .o_flg_pc_modify (dec_pc_modify),
        .o_flg_link_ret  (dec_link_ret),
        .o_flg_addr_type (dec_addr_type),
        .o_link_reg      (dec_link_reg),
        .o_flg_equal     (dec_equal),
        .o_flg_immediate (dec_immediate),
        .o_flg_mem_op    (dec_mem_op),
        .o_flg_mem_type  (dec_mem_type),
        .o_flg_mem_size  (dec_mem_size),
        .o_flg_unsign    (dec_unsign),
        .o_illegal       (dec_illegal)
    );

    register_file register_file_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_rd_addr_a (dec_rs),
        .i_rd_addr_b (dec_rt),
        .o_rd_data_a (rs_data),
        .o_rd_data_b (rt_data),
        .i_wr_en     (i_wb_en),
        .i_wr_addr   (i_wb_addr),
        .i_wr_data   (i_wb_data)
    );

    branch_resolver branch_resolver_inst (
        .i_pc          (i_pc),
        .i_rs_data     (rs_data),
        .i_rt_data     (rt_data),
        .i_pc_modify   (dec_pc_modify),
        .i_equal       (dec_equal),
        .i_link_ret    (dec_link_ret),
        .i_addr_type   (dec_addr_type),
        .i_addr_offset (dec_addr_offset),
        .i_link_reg    (dec_link_reg),
        .o_taken       (br_taken),
        .o_target      (br_target),
        .o_link_en     (br_link_en),
        .o_link_reg    (br_link_reg),
        .o_link_data   (br_link_data)
    );

    // ID/EX register, payload holds while no instruction arrives
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid         <= 1'b0;
            o_funct         <= '0;
            o_rs_data       <= '0;
            o_rt_data       <= '0;
            o_rt            <= '0;
            o_rd            <= '0;
            o_shamt         <= '0;
            o_imm           <= '0;
            o_immediate     <= 1'b0;
            o_mem_op        <= 1'b0;
            o_mem_store     <= 1'b0;
            o_mem_size      <= '0;
            o_unsign        <= 1'b0;
            o_branch_taken  <= 1'b0;
            o_branch_target <= '0;
            o_link_en       <= 1'b0;
            o_link_reg      <= '0;
            o_link_data     <= '0;
            o_illegal       <= 1'b0;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin
                o_funct         <= dec_funct;
                o_rs_data       <= rs_data;
                o_rt_data       <= rt_data;
                o_rt            <= dec_rt;
                o_rd            <= dec_rd;
                o_shamt         <= dec_shamt;
                o_imm           <= dec_imm;
                o_immediate     <= dec_immediate;
                o_mem_op        <= dec_mem_op;
                o_mem_store     <= dec_mem_type;  // Store when type is set
                o_mem_size      <= dec_mem_size;
                o_unsign        <= dec_unsign;
                o_branch_taken  <= br_taken;
                o_branch_target <= br_target;
                o_link_en       <= br_link_en;
                o_link_reg      <= br_link_reg;
                o_link_data     <= br_link_data;
                o_illegal       <= dec_illegal;
            end
        end
    end

endmodule

// ==== branch_resolver.sv ====
`timescale 1ns/10ps

module branch_resolver (
    input  logic [31:0] i_pc,
    input  logic [31:0] i_rs_data,
    input  logic [31:0] i_rt_data,

    input  logic        i_pc_modify,
    input  logic        i_equal,
    input  logic        i_link_ret,
    input  logic [1:0]  i_addr_type,
    input  logic [25:0] i_addr_offset,
    input  logic [4:0]  i_link_reg,

    output logic        o_taken,
    output logic [31:0] o_target,
    output logic        o_link_en,
    output logic [4:0]  o_link_reg,
    output logic [31:0] o_link_data
);

    logic [mips_pkg::DATA_W-1:0] pc_plus4;
    logic [mips_pkg::DATA_W-1:0] branch_offset;
    logic                        operands_equal;

    assign pc_plus4       = i_pc + 32'd4;
    assign branch_offset  = {{14{i_addr_offset[15]}}, i_addr_offset[15:0], 2'b00};  // Word offset
    assign operands_equal = (i_rs_data == i_rt_data);

    always_comb begin
        o_taken  = 1'b0;
        o_target = '0;
        if (i_pc_modify) begin
            case (i_addr_type)
                mips_pkg::ADDR_REG: begin
                    o_taken  = 1'b1;
                    o_target = i_rs_data;
                end
                mips_pkg::ADDR_JUMP: begin
                    o_taken  = 1'b1;
                    o_target = {i_pc[31:28], i_addr_offset, 2'b00};
                end
                mips_pkg::ADDR_BRANCH: begin
                    o_taken  = (operands_equal == i_equal);  // BEQ on equal, BNE otherwise
                    o_target = pc_plus4 + branch_offset;
                end
                default: ;
            endcase
        end
    end

    // No delay slot, return to the next instruction
    assign o_link_en   = i_link_ret;
    assign o_link_reg  = i_link_ret ? i_link_reg : '0;
    assign o_link_data = i_link_ret ? pc_plus4 : '0;

endmodule

// ==== register_file.sv ====
`timescale 1ns/10ps

module register_file (
    input  logic        i_clk,
    input  logic        i_rst_n,

    input  logic [4:0]  i_rd_addr_a,
    input  logic [4:0]  i_rd_addr_b,
    output logic [31:0] o_rd_data_a,
    output logic [31:0] o_rd_data_b,

    input  logic        i_wr_en,
    input  logic [4:0]  i_wr_addr,
    input  logic [31:0] i_wr_data
);

    logic [mips_pkg::DATA_W-1:0] gpr [mips_pkg::NUM_GPR];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < mips_pkg::NUM_GPR; i++) begin
                gpr[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_addr != '0)) begin  // Register 0 is never written
            gpr[i_wr_addr] <= i_wr_data;
        end
    end

    // No bypass, a write shows up on the next cycle
    assign o_rd_data_a = (i_rd_addr_a == '0) ? '0 : gpr[i_rd_addr_a];
    assign o_rd_data_b = (i_rd_addr_b == '0) ? '0 : gpr[i_rd_addr_b];

endmodule

// ==== instruction_decoder.sv ====
`timescale 1ns/10ps

module instruction_decoder (
    input  logic [31:0] i_instr,

    output logic [5:0]  o_funct,          // ALU function, or low opcode bits for I type
    output logic [4:0]  o_rs,
    output logic [4:0]  o_rt,
    output logic [4:0]  o_rd,
    output logic [4:0]  o_shamt,
    output logic [15:0] o_imm,
    output logic [25:0] o_addr_offset,    // Jump target or branch offset

    output logic        o_flg_pc_modify,  // Jump or branch
    output logic        o_flg_link_ret,   // Saves return address
    output logic [1:0]  o_flg_addr_type,  // Target address source
    output logic [4:0]  o_link_reg,
    output logic        o_flg_equal,      // Branch taken on equal operands
    output logic        o_flg_immediate,  // Second operand is the immediate
    output logic        o_flg_mem_op,
    output logic        o_flg_mem_type,   // 0 load, 1 store
    output logic [1:0]  o_flg_mem_size,
    output logic        o_flg_unsign,
    output logic        o_illegal
);

    mips_pkg::instr_t instr;

    assign instr = i_instr;

    always_comb begin
        o_funct         = '0;
        o_rs            = '0;
        o_rt            = '0;
        o_rd            = '0;
        o_shamt         = '0;
        o_imm           = '0;
        o_addr_offset   = '0;
        o_flg_pc_modify = 1'b0;
        o_flg_link_ret  = 1'b0;
        o_flg_addr_type = mips_pkg::ADDR_REG;
        o_link_reg      = '0;
        o_flg_equal     = 1'b0;
        o_flg_immediate = 1'b0;
        o_flg_mem_op    = 1'b0;
        o_flg_mem_type  = 1'b0;
        o_flg_mem_size  = mips_pkg::MEM_BYTE;
        o_flg_unsign    = 1'b0;
        o_illegal       = 1'b0;

        case (instr.r_fmt.opcode)
            mips_pkg::OP_RTYPE: begin
                o_rs = instr.r_fmt.rs;
                case (instr.r_fmt.funct)
                    mips_pkg::FN_JR: begin
                        o_flg_pc_modify = 1'b1;
                        o_flg_addr_type = mips_pkg::ADDR_REG;
                    end
                    mips_pkg::FN_JALR: begin
                        o_rd            = instr.r_fmt.rd;
                        o_flg_pc_modify = 1'b1;
                        o_flg_link_ret  = 1'b1;
                        o_flg_addr_type = mips_pkg::ADDR_REG;
                        o_link_reg      = instr.r_fmt.rd;  // Link goes to rd
                    end
                    default: begin                         // ALU operations
                        o_funct = instr.r_fmt.funct;
                        o_rt    = instr.r_fmt.rt;
                        o_rd    = instr.r_fmt.rd;
                        o_shamt = instr.r_fmt.shamt;
                    end
                endcase
            end
            mips_pkg::OP_J, mips_pkg::OP_JAL: begin
                o_addr_offset   = instr.j_fmt.target;
                o_flg_pc_modify = 1'b1;
                o_flg_addr_type = mips_pkg::ADDR_JUMP;
                if (instr.j_fmt.opcode == mips_pkg::OP_JAL) begin
                    o_flg_link_ret = 1'b1;
                    o_link_reg     = mips_pkg::GPR_RA;
                end
            end
            mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
                o_rs            = instr.i_fmt.rs;
                o_rt            = instr.i_fmt.rt;
                o_addr_offset   = {10'b0, instr.i_fmt.imm};  // Sign extended later
                o_flg_pc_modify = 1'b1;
                o_flg_addr_type = mips_pkg::ADDR_BRANCH;
                o_flg_equal     = (instr.i_fmt.opcode == mips_pkg::OP_BEQ);
            end
            default: begin
                // Remaining I type groups share the field layout
                o_rs    = instr.i_fmt.rs;
                o_rt    = instr.i_fmt.rt;
                o_imm   = instr.i_fmt.imm;
                o_funct = {3'b0, instr.i_fmt.opcode[2:0]};
                o_flg_immediate = 1'b1;
                case (instr.i_fmt.opcode[5:3])
                    mips_pkg::OPG_ARITH: ;
                    mips_pkg::OPG_LOAD: begin
                        o_flg_mem_op   = 1'b1;
                        o_flg_mem_size = instr.i_fmt.opcode[1:0];
                        o_flg_unsign   = instr.i_fmt.opcode[2];  // LBU, LHU, LWU
                    end
                    mips_pkg::OPG_STORE: begin
                        o_flg_mem_op   = 1'b1;
                        o_flg_mem_type = 1'b1;
                        o_flg_mem_size = instr.i_fmt.opcode[1:0];
                    end
                    default: begin
                        // Undefined opcode, only the flag stays set
                        o_rs            = '0;
                        o_rt            = '0;
                        o_imm           = '0;
                        o_funct         = '0;
                        o_flg_immediate = 1'b0;
                        o_illegal       = 1'b1;
                    end
                endcase
            end
        endcase
    end

endmodule

// ==== mips_pkg.sv ====
package mips_pkg;

    // Data path and field widths
    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_GPR    = 32;
    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;
    localparam int SHAMT_W    = 5;
    localparam int IMM_W      = 16;
    localparam int TARGET_W   = 26;
    localparam int OPG_W      = 3;

    // Full opcodes
    localparam logic [OPCODE_W-1:0] OP_RTYPE = 6'b000000;
    localparam logic [OPCODE_W-1:0] OP_J     = 6'b000010;
    localparam logic [OPCODE_W-1:0] OP_JAL   = 6'b000011;
    localparam logic [OPCODE_W-1:0] OP_BEQ   = 6'b000100;
    localparam logic [OPCODE_W-1:0] OP_BNE   = 6'b000101;

    // Opcode groups, upper three opcode bits
    localparam logic [OPG_W-1:0] OPG_ARITH = 3'b001;
    localparam logic [OPG_W-1:0] OPG_LOAD  = 3'b100;
    localparam logic [OPG_W-1:0] OPG_STORE = 3'b101;

    // Register jump funct codes
    localparam logic [FUNCT_W-1:0] FN_JR   = 6'b001000;
    localparam logic [FUNCT_W-1:0] FN_JALR = 6'b001001;

    // Source of the jump or branch target
    localparam logic [1:0] ADDR_REG    = 2'b00;  // Value of rs
    localparam logic [1:0] ADDR_JUMP   = 2'b01;  // PC upper bits and 26-bit offset
    localparam logic [1:0] ADDR_BRANCH = 2'b10;  // PC+4 plus signed 16-bit offset

    // Memory access sizes, same as opcode bits 1:0 of loads and stores
    localparam logic [1:0] MEM_BYTE = 2'b00;
    localparam logic [1:0] MEM_HALF = 2'b01;
    localparam logic [1:0] MEM_WORD = 2'b11;

    localparam logic [REG_ADDR_W-1:0] GPR_RA = 5'd31;  // Return address register

    typedef struct packed {
        logic [OPCODE_W-1:0]   opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [SHAMT_W-1:0]    shamt;
        logic [FUNCT_W-1:0]    funct;
    } r_fmt_t;

    typedef struct packed {
        logic [OPCODE_W-1:0]   opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [IMM_W-1:0]      imm;
    } i_fmt_t;

    typedef struct packed {
        logic [OPCODE_W-1:0] opcode;
        logic [TARGET_W-1:0] target;
    } j_fmt_t;

    // One instruction word, three ways to read it
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } instr_t;

endpackage
